// ==== design/core_ctrl.sv ====
// core controller: fetch/run sequencing, instruction-cycle count and pc
`default_nettype none

module core_ctrl
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             fetch_done,
  output logic                  fetch_start,
  output logic [CYC_W-1:0]      inst_cycle,
  output logic [XLEN-1:0]       pc,
  input  wire logic             pc_jmp,
  input  wire logic [XLEN-1:0]  pc_jmpaddr
);

  core_state_e state;

  // one-cycle kick, the fetch unit runs the handshake itself
  assign fetch_start = (state == ST_FETCH);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_FETCH;
      inst_cycle <= '0;
      pc         <= RESET_PC;
    end else begin
      case (state)
        ST_FETCH: begin
          state <= ST_RELEASE;
        end
        ST_RELEASE: begin
          // fetch_done comes after ack has dropped
          if (fetch_done) begin
            state      <= ST_RUN;
            inst_cycle <= CYC_DECODE;
          end
        end
        ST_RUN: begin
          if (inst_cycle == CYC_WB) begin
            state      <= ST_FETCH;
            inst_cycle <= '0;
            pc         <= pc_jmp ? pc_jmpaddr : pc + XLEN'(4);
          end else begin
            inst_cycle <= inst_cycle + 1'b1;
          end
        end
        default: begin
          state      <= ST_FETCH;
          inst_cycle <= '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/core_ctrl_pkg.sv ====
// core controller package: sequencer states and instruction-cycle counts
`default_nettype none

package core_ctrl_pkg;

  typedef enum logic [1:0] {
    ST_FETCH   = 2'd0,
    ST_RELEASE = 2'd1,
    ST_RUN     = 2'd2
  } core_state_e;

  localparam int CYC_W = 3;

  // counts seen while in ST_RUN
  localparam logic [CYC_W-1:0] CYC_DECODE = 3'd1;
  localparam logic [CYC_W-1:0] CYC_EXEC   = 3'd2;
  localparam logic [CYC_W-1:0] CYC_WB     = 3'd3;

endpackage

`default_nettype wire

// ==== design/dec_exe_if.sv ====
// decoder to execute bundle: decoded operation fields and formed operands
`default_nettype none

interface dec_exe_if
  import rv_isa_pkg::*;
();

  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [XLEN-1:0]  op1;
  logic [XLEN-1:0]  op2;
  logic [XLEN-1:0]  t1;

  modport dec (
    output opcode, funct3, funct7, op1, op2, t1
  );

  modport exe (
    input opcode, funct3, funct7, op1, op2, t1
  );

endinterface

`default_nettype wire

// ==== design/exe_stage.sv ====
// execute stage: result, branch/jump resolution and cycle-gated rd write
`default_nettype none

module exe_stage
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic [CYC_W-1:0] inst_cycle,
  dec_exe_if.exe                dx,
  output logic                  pc_jmp,
  output logic [XLEN-1:0]       pc_jmpaddr,
  output logic                  rd_wen,
  output logic [XLEN-1:0]       rd_data
);

  logic             wr_intent;
  logic             take;
  logic [XLEN-1:0]  target;
  logic             lt_s;
  logic             lt_u;

  assign lt_s = $signed(dx.op1) < $signed(dx.op2);
  assign lt_u = dx.op1 < dx.op2;

  // write intent and result
  always_comb begin
    wr_intent = 1'b0;
    rd_data   = '0;
    case (dx.opcode)
      OPC_AUIPC: begin
        wr_intent = 1'b1;
        rd_data   = dx.op1 + dx.op2;
      end
      OPC_OP_IMM: begin
        case (dx.funct3)
          F3_ADDI: begin
            wr_intent = 1'b1;
            rd_data   = dx.op1 + dx.op2;
          end
          F3_SLTI: begin
            wr_intent = 1'b1;
            rd_data   = {{(XLEN-1){1'b0}}, lt_s};
          end
          F3_SLTIU: begin
            wr_intent = 1'b1;
            rd_data   = {{(XLEN-1){1'b0}}, lt_u};
          end
          default: wr_intent = 1'b0;
        endcase
      end
      OPC_JAL: begin
        wr_intent = 1'b1;
        rd_data   = dx.op1;
      end
      OPC_JALR: begin
        wr_intent = 1'b1;
        rd_data   = dx.t1;
      end
      default: wr_intent = 1'b0;
    endcase
  end

  assign rd_wen = wr_intent && (inst_cycle == CYC_WB);

  // jump decision
  always_comb begin
    take   = 1'b0;
    target = dx.t1;
    case (dx.opcode)
      OPC_JAL: begin
        take   = 1'b1;
        target = dx.op2;
      end
      OPC_JALR: begin
        take   = 1'b1;
        target = (dx.op1 + dx.op2) & ~XLEN'(1);
      end
      OPC_BRANCH: begin
        case (dx.funct3)
          F3_BEQ:  take = dx.op1 == dx.op2;
          F3_BNE:  take = dx.op1 != dx.op2;
          F3_BLT:  take = lt_s;
          F3_BGE:  take = !lt_s;
          F3_BLTU: take = lt_u;
          F3_BGEU: take = !lt_u;
          default: take = 1'b0;
        endcase
      end
      default: take = 1'b0;
    endcase
  end

  // captured at the end of the exec cycle, held through wb
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_jmp <= 1'b0;
    end else if (inst_cycle == CYC_EXEC) begin
      pc_jmp <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_cycle == CYC_EXEC) begin
      pc_jmpaddr <= target;
    end
  end

endmodule

`default_nettype wire

// ==== design/inst_decode.sv ====
// instruction decode: field split, immediates and per-class operand forming
`default_nettype none

module inst_decode
  import rv_isa_pkg::*;
(
  input  wire logic [ILEN-1:0]  inst,
  input  wire logic [XLEN-1:0]  pc,
  output logic [4:0]            rs1_addr,
  output logic [4:0]            rs2_addr,
  output logic [4:0]            rd_addr,
  input  wire logic [XLEN-1:0]  rs1_data,
  input  wire logic [XLEN-1:0]  rs2_data,
  dec_exe_if.dec                dx
);

  opcode_e          opc;
  logic [XLEN-1:0]  imm_i;
  logic [XLEN-1:0]  imm_u;
  logic [XLEN-1:0]  imm_j;
  logic [XLEN-1:0]  imm_b;
  logic [XLEN-1:0]  pc_plus4;

  assign opc      = opcode_e'(inst[6:2]);
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];
  assign rd_addr  = inst[11:7];

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  // scrambled offsets, bit 0 implied zero
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

  assign pc_plus4 = pc + XLEN'(4);

  assign dx.opcode = opc;
  assign dx.funct3 = inst[14:12];
  assign dx.funct7 = inst[31:25];

  always_comb begin
    dx.op1 = '0;
    dx.op2 = '0;
    dx.t1  = '0;
    case (opc)
      OPC_AUIPC: begin
        dx.op1 = pc;
        dx.op2 = imm_u;
      end
      OPC_OP_IMM: begin
        dx.op1 = rs1_data;
        dx.op2 = imm_i;
      end
      OPC_JAL: begin
        // link value and target both precomputed here
        dx.op1 = pc_plus4;
        dx.op2 = pc + imm_j;
      end
      OPC_JALR: begin
        dx.op1 = rs1_data;
        dx.op2 = imm_i;
        dx.t1  = pc_plus4;
      end
      OPC_BRANCH: begin
        dx.op1 = rs1_data;
        dx.op2 = rs2_data;
        dx.t1  = pc + imm_b;
      end
      default: begin
        dx.op1 = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/inst_fetch.sv ====
// instruction fetch: four-phase imem requester and instruction register
`default_nettype none

module inst_fetch
  import rv_isa_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             fetch_start,
  input  wire logic [XLEN-1:0]  pc,
  output logic                  imem_req,
  output logic [XLEN-1:0]       imem_addr,
  input  wire logic             imem_ack,
  input  wire logic [ILEN-1:0]  imem_rdata,
  output logic                  fetch_done,
  output logic [ILEN-1:0]       inst
);

  // set between ack rising and ack falling
  logic wait_low;

  always_ff @(posedge clk) begin
    if (rst) begin
      imem_req   <= 1'b0;
      wait_low   <= 1'b0;
      fetch_done <= 1'b0;
    end else begin
      fetch_done <= 1'b0;
      if (!imem_req && !wait_low) begin
        // never raise req over a stale ack
        if (fetch_start && !imem_ack) begin
          imem_req <= 1'b1;
        end
      end else if (imem_req) begin
        if (imem_ack) begin
          imem_req <= 1'b0;
          wait_low <= 1'b1;
        end
      end else if (!imem_ack) begin
        wait_low   <= 1'b0;
        fetch_done <= 1'b1;
      end
    end
  end

  // address held for the whole request phase
  always_ff @(posedge clk) begin
    if (!imem_req && !wait_low && fetch_start) begin
      imem_addr <= pc;
    end
  end

  always_ff @(posedge clk) begin
    if (imem_req && imem_ack) begin
      inst <= imem_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== design/regfile.sv ====
// integer register file: 32 x 64 bits, two async reads, one sync write
`default_nettype none

module regfile
  import rv_isa_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic [4:0]       rs1_addr,
  input  wire logic [4:0]       rs2_addr,
  output logic [XLEN-1:0]       rs1_data,
  output logic [XLEN-1:0]       rs2_data,
  input  wire logic             wen,
  input  wire logic [4:0]       rd_addr,
  input  wire logic [XLEN-1:0]  rd_data
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // x0 reads as zero whatever was stored there
  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== design/rv_core_top.sv ====
// rv64 multi-cycle core top: fetch, decode, execute and register file
`default_nettype none

module rv_core_top
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst,
  output logic                  imem_req,
  output logic [XLEN-1:0]       imem_addr,
  input  wire logic             imem_ack,
  input  wire logic [ILEN-1:0]  imem_rdata,
  output logic                  wb_en,
  output logic [4:0]            wb_rd,
  output logic [XLEN-1:0]       wb_data
);

  logic             fetch_start;
  logic             fetch_done;
  logic [ILEN-1:0]  inst;
  logic [XLEN-1:0]  pc;
  logic [CYC_W-1:0] inst_cycle;
  logic             pc_jmp;
  logic [XLEN-1:0]  pc_jmpaddr;
  logic [4:0]       rs1_addr;
  logic [4:0]       rs2_addr;
  logic [4:0]       rd_addr;
  logic [XLEN-1:0]  rs1_data;
  logic [XLEN-1:0]  rs2_data;
  logic             rd_wen;
  logic [XLEN-1:0]  rd_data;

  dec_exe_if dx ();

  // x0 writes dropped here for both regfile and writeback port
  assign wb_en   = rd_wen && (rd_addr != 5'd0);
  assign wb_rd   = rd_addr;
  assign wb_data = rd_data;

  inst_fetch u_fetch (
    .clk         (clk),
    .rst         (rst),
    .fetch_start (fetch_start),
    .pc          (pc),
    .imem_req    (imem_req),
    .imem_addr   (imem_addr),
    .imem_ack    (imem_ack),
    .imem_rdata  (imem_rdata),
    .fetch_done  (fetch_done),
    .inst        (inst)
  );

  core_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .fetch_done  (fetch_done),
    .fetch_start (fetch_start),
    .inst_cycle  (inst_cycle),
    .pc          (pc),
    .pc_jmp      (pc_jmp),
    .pc_jmpaddr  (pc_jmpaddr)
  );

  regfile u_rf (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (wb_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  inst_decode u_dec (
    .inst     (inst),
    .pc       (pc),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dx       (dx.dec)
  );

  exe_stage u_exe (
    .clk        (clk),
    .rst        (rst),
    .inst_cycle (inst_cycle),
    .dx         (dx.exe),
    .pc_jmp     (pc_jmp),
    .pc_jmpaddr (pc_jmpaddr),
    .rd_wen     (rd_wen),
    .rd_data    (rd_data)
  );

endmodule

`default_nettype wire

// ==== design/rv_isa_pkg.sv ====
// rv64 isa package: widths, opcode and funct3 encodings, reset vector
`default_nettype none

package rv_isa_pkg;

  localparam int XLEN = 64;
  localparam int ILEN = 32;

  localparam logic [XLEN-1:0] RESET_PC = '0;

  // instruction bits 6..2, low two bits are always 2'b11
  typedef enum logic [4:0] {
    OPC_OP_IMM = 5'b00100,
    OPC_AUIPC  = 5'b00101,
    OPC_BRANCH = 5'b11000,
    OPC_JALR   = 5'b11001,
    OPC_JAL    = 5'b11011
  } opcode_e;

  typedef enum logic [2:0] {
    F3_ADDI  = 3'b000,
    F3_SLTI  = 3'b010,
    F3_SLTIU = 3'b011
  } op_imm_f3_e;

  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGE  = 3'b101,
    F3_BLTU = 3'b110,
    F3_BGEU = 3'b111
  } branch_f3_e;

endpackage

`default_nettype wire

// ==== rv_core.f ====
design/rv_isa_pkg.sv
design/core_ctrl_pkg.sv
design/dec_exe_if.sv
design/inst_fetch.sv
design/regfile.sv
design/inst_decode.sv
design/exe_stage.sv
design/core_ctrl.sv
design/rv_core_top.sv
test/imem_model.sv
test/core_tb.sv

// ==== test/core_tb.sv ====
// core testbench: clock, reset, reference ISA model and assertion checks
`default_nettype none

module core_tb
  import rv_isa_pkg::*;
();

  localparam int FETCH_TIMEOUT = 64;
  localparam int MAX_FETCH     = 120;
  localparam logic [ILEN-1:0] HALT_INST = 32'h0000_006f;

  logic             clk;
  logic             rst;
  logic             imem_req;
  logic [XLEN-1:0]  imem_addr;
  logic             imem_ack;
  logic [ILEN-1:0]  imem_rdata;
  logic             wb_en;
  logic [4:0]       wb_rd;
  logic [XLEN-1:0]  wb_data;

  logic [XLEN-1:0]  ref_regs [32];
  logic [XLEN-1:0]  ref_pc;
  logic [4:0]       exp_rd_q [$];
  logic [XLEN-1:0]  exp_data_q [$];

  int fetches = 0;
  int halts = 0;
  int writebacks = 0;
  int mismatches = 0;
  int sequence_errors = 0;
  int protocol_errors = 0;

  rv_core_top dut (
    .clk        (clk),
    .rst        (rst),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_ack   (imem_ack),
    .imem_rdata (imem_rdata),
    .wb_en      (wb_en),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

  imem_model u_imem (
    .clk   (clk),
    .rst   (rst),
    .req   (imem_req),
    .addr  (imem_addr),
    .ack   (imem_ack),
    .rdata (imem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic mismatch_seen(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
    $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    mismatches++;
  endtask

  task automatic protocol_violation(input string what);
    $display("ERROR at %0t: %s", $time, what);
    protocol_errors++;
  endtask

  task automatic sequence_violation(input string what);
    $display("ERROR at %0t: %s", $time, what);
    sequence_errors++;
  endtask

  // architectural step of one fetched instruction
  task automatic model_step(input logic [ILEN-1:0] ins);
    logic [4:0]      rd;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] result;
    logic            writes;
    logic            taken;
    rd      = ins[11:7];
    a       = ref_regs[ins[19:15]];
    b       = ref_regs[ins[24:20]];
    imm_i   = {{52{ins[31]}}, ins[31:20]};
    imm_b   = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j   = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    next_pc = ref_pc + 64'd4;
    result  = '0;
    writes  = 1'b0;
    taken   = 1'b0;
    case (ins[6:2])
      OPC_AUIPC: begin
        writes = 1'b1;
        result = ref_pc + {{32{ins[31]}}, ins[31:12], 12'h000};
      end
      OPC_OP_IMM: begin
        writes = 1'b1;
        case (ins[14:12])
          F3_ADDI:  result = a + imm_i;
          F3_SLTI:  result = ($signed(a) < $signed(imm_i)) ? 64'd1 : 64'd0;
          F3_SLTIU: result = (a < imm_i) ? 64'd1 : 64'd0;
          default:  writes = 1'b0;
        endcase
      end
      OPC_JAL: begin
        writes  = 1'b1;
        result  = ref_pc + 64'd4;
        next_pc = ref_pc + imm_j;
      end
      OPC_JALR: begin
        writes  = 1'b1;
        result  = ref_pc + 64'd4;
        next_pc = (a + imm_i) & ~64'd1;
      end
      OPC_BRANCH: begin
        case (ins[14:12])
          F3_BEQ:  taken = (a == b);
          F3_BNE:  taken = (a != b);
          F3_BLT:  taken = ($signed(a) < $signed(b));
          F3_BGE:  taken = ($signed(a) >= $signed(b));
          F3_BLTU: taken = (a < b);
          F3_BGEU: taken = (a >= b);
          default: taken = 1'b0;
        endcase
        if (taken) begin
          next_pc = ref_pc + imm_b;
        end
      end
      default: writes = 1'b0;
    endcase
    if (writes && rd != 5'd0) begin
      ref_regs[rd] = result;
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(result);
    end
    ref_pc = next_pc;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      ref_pc = RESET_PC;
      for (int i = 0; i < 32; i++) begin
        ref_regs[i] = '0;
      end
      exp_rd_q.delete();
      exp_data_q.delete();
    end else begin
      if (imem_req && imem_ack) begin
        fetch_addr_check: assert (imem_addr == ref_pc)
          else mismatch_seen("fetch address", imem_addr, ref_pc);
        prev_wb_check: assert (exp_rd_q.size() == 0)
          else sequence_violation($sformatf("previous instruction never wrote x%0d",
                                            exp_rd_q[0]));
        exp_rd_q.delete();
        exp_data_q.delete();
        model_step(imem_rdata);
        fetches++;
        if (imem_rdata == HALT_INST) begin
          halts++;
        end
      end
      if (wb_en) begin
        writebacks++;
        wb_expected_check: assert (exp_rd_q.size() != 0)
          else sequence_violation($sformatf("unexpected writeback to x%0d", wb_rd));
        if (exp_rd_q.size() != 0) begin
          wb_rd_check: assert (wb_rd == exp_rd_q[0])
            else mismatch_seen("writeback rd", XLEN'(wb_rd), XLEN'(exp_rd_q[0]));
          wb_data_check: assert (wb_data == exp_data_q[0])
            else mismatch_seen("writeback data", wb_data, exp_data_q[0]);
          exp_rd_q.delete(0);
          exp_data_q.delete(0);
        end
      end
    end
  end

  reset_state_check: assert property (@(posedge clk) $fell(rst) |-> !imem_req && !wb_en)
    else protocol_violation("imem_req or wb_en not low after reset");

  req_rise_check: assert property (@(posedge clk) disable iff (rst)
    $rose(imem_req) |-> !$past(imem_ack))
    else protocol_violation("imem_req rose while imem_ack was still high");

  addr_stable_check: assert property (@(posedge clk) disable iff (rst)
    imem_req && $past(imem_req) |-> $stable(imem_addr))
    else protocol_violation("imem_addr changed while imem_req was high");

  wb_x0_check: assert property (@(posedge clk) disable iff (rst) wb_en |-> wb_rd != 5'd0)
    else protocol_violation("writeback to x0 appeared on wb_en");

  wb_pulse_check: assert property (@(posedge clk) disable iff (rst) wb_en |=> !wb_en)
    else protocol_violation("wb_en held high for more than one cycle");

  initial begin
    int cyc;
    int last;
    int run_errors;
    bit stuck;
    run_errors = 0;
    stuck      = 1'b0;
    rst        = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    // run until the halt loop has been fetched twice
    while (halts < 2 && !stuck) begin
      last = fetches;
      cyc  = 0;
      while (fetches == last && cyc < FETCH_TIMEOUT) begin
        @(negedge clk);
        cyc++;
      end
      if (fetches == last) begin
        $display("ERROR: no instruction fetch completed within %0d cycles", FETCH_TIMEOUT);
        run_errors++;
        stuck = 1'b1;
      end else if (fetches > MAX_FETCH) begin
        $display("ERROR: halt loop not reached after %0d fetches", MAX_FETCH);
        run_errors++;
        stuck = 1'b1;
      end
    end
    $display("fetches=%0d writebacks=%0d mismatches=%0d protocol=%0d sequence=%0d run=%0d",
             fetches, writebacks, mismatches, protocol_errors, sequence_errors, run_errors);
    if (mismatches + protocol_errors + sequence_errors + run_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/imem_model.sv ====
// instruction memory model: preloaded test program behind a four-phase responder
`default_nettype none

module imem_model
  import rv_isa_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             req,
  input  wire logic [XLEN-1:0]  addr,
  output logic                  ack,
  output logic [ILEN-1:0]       rdata
);

  logic [ILEN-1:0] rom [64];
  logic [5:0]      n;
  integer          seed;
  integer          delay;

  function automatic logic [ILEN-1:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input opcode_e opc);
    enc_i = {imm, rs1, f3, rd, opc, 2'b11};
  endfunction

  function automatic logic [ILEN-1:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    enc_u = {imm, rd, OPC_AUIPC, 2'b11};
  endfunction

  function automatic logic [ILEN-1:0] enc_b(input logic [12:0] off, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [2:0] f3);
    enc_b = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH, 2'b11};
  endfunction

  function automatic logic [ILEN-1:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    enc_j = {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL, 2'b11};
  endfunction

  task automatic put(input logic [ILEN-1:0] w);
    rom[n] = w;
    n = n + 6'd1;
  endtask

  // taken form skips a marker on x9, not-taken form runs one on x10
  task automatic branch_pair(input logic [2:0] f3,
                             input logic [4:0] rs1_t, input logic [4:0] rs2_t,
                             input logic [4:0] rs1_n, input logic [4:0] rs2_n);
    put(enc_b(13'd8, rs1_t, rs2_t, f3));
    put(enc_i(12'd1, 5'd9, F3_ADDI, 5'd9, OPC_OP_IMM));
    put(enc_b(13'd8, rs1_n, rs2_n, f3));
    put(enc_i(12'd1, 5'd10, F3_ADDI, 5'd10, OPC_OP_IMM));
  endtask

  initial begin
    seed  = 32'h5cab2eb8;
    ack   = 1'b0;
    rdata = '0;
    delay = $unsigned($random(seed)) % 6;
    // unused words are addi x0 with the word index as immediate
    for (int i = 0; i < 64; i++) begin
      rom[6'(i)] = enc_i(12'(i), 5'd0, F3_ADDI, 5'd0, OPC_OP_IMM);
    end
    n = '0;
    put(enc_i(12'd5, 5'd0, F3_ADDI, 5'd1, OPC_OP_IMM));
    put(enc_i(-12'sd3, 5'd0, F3_ADDI, 5'd2, OPC_OP_IMM));
    put(enc_i(12'd7, 5'd1, F3_ADDI, 5'd0, OPC_OP_IMM));
    put(enc_u(20'h12345, 5'd3));
    // signed and unsigned orderings differ for x1 = 5, x2 = -3
    put(enc_i(12'd1, 5'd2, F3_SLTI, 5'd4, OPC_OP_IMM));
    put(enc_i(12'd1, 5'd2, F3_SLTIU, 5'd5, OPC_OP_IMM));
    put(enc_i(-12'sd1, 5'd1, F3_SLTI, 5'd6, OPC_OP_IMM));
    put(enc_i(-12'sd1, 5'd1, F3_SLTIU, 5'd7, OPC_OP_IMM));
    branch_pair(F3_BEQ, 5'd1, 5'd1, 5'd1, 5'd2);
    branch_pair(F3_BNE, 5'd1, 5'd2, 5'd1, 5'd1);
    branch_pair(F3_BLT, 5'd2, 5'd1, 5'd1, 5'd2);
    branch_pair(F3_BGE, 5'd1, 5'd2, 5'd2, 5'd1);
    branch_pair(F3_BLTU, 5'd1, 5'd2, 5'd2, 5'd1);
    branch_pair(F3_BGEU, 5'd2, 5'd1, 5'd1, 5'd2);
    // backward branch loop, three passes
    put(enc_i(12'd3, 5'd0, F3_ADDI, 5'd11, OPC_OP_IMM));
    put(enc_i(-12'sd1, 5'd11, F3_ADDI, 5'd11, OPC_OP_IMM));
    put(enc_b(-13'sd4, 5'd11, 5'd0, F3_BNE));
    put(enc_j(21'd8, 5'd12));
    put(enc_i(12'd1, 5'd0, F3_ADDI, 5'd15, OPC_OP_IMM));
    // jalr target is odd before bit 0 is cleared
    put(enc_u(20'h0, 5'd13));
    put(enc_i(12'd13, 5'd13, 3'b000, 5'd14, OPC_JALR));
    put(enc_i(12'd1, 5'd0, F3_ADDI, 5'd15, OPC_OP_IMM));
    put(enc_j(21'd0, 5'd0));
  end

  always @(negedge clk) begin
    if (rst) begin
      ack <= 1'b0;
    end else if (req && !ack) begin
      if (delay == 0) begin
        ack   <= 1'b1;
        rdata <= rom[addr[7:2]];
        delay <= $unsigned($random(seed)) % 6;
      end else begin
        delay <= delay - 1;
      end
    end else if (ack && !req) begin
      if (delay == 0) begin
        ack   <= 1'b0;
        delay <= $unsigned($random(seed)) % 6;
      end else begin
        delay <= delay - 1;
      end
    end
  end

endmodule

`default_nettype wire
